/* include/rd_settings.svh */
`ifndef RD_SETTINGS_SVH
`define RD_SETTINGS_SVH

// requestors, and engines behind them
`define RD_PORTS 2

// bus widths
`define RD_ADDR_W 32
`define RD_DATA_W 64
`define RD_ID_W 4
`define RD_LEN_W 8 // beats minus one

// external AXI encodings
`define RD_AXSIZE_W 3
`define RD_BURST_W 2
`define RD_BURST_INCR 2'b01

`endif

/* verilog/rd_pkg.sv */
`default_nettype none

`include "rd_settings.svh"

package rd_pkg;

	// access size, log2 of the byte count
	typedef enum logic [1:0] {
		SZ_B = 2'b00,
		SZ_H = 2'b01,
		SZ_W = 2'b10,
		SZ_D = 2'b11
	} rd_size_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} rd_resp_e;

	// one beat seen at every lane granularity
	typedef union packed {
		logic [`RD_DATA_W/8-1:0][7:0]   bytes;
		logic [`RD_DATA_W/16-1:0][15:0] halves;
		logic [`RD_DATA_W/32-1:0][31:0] words;
		logic [`RD_DATA_W-1:0]          dword;
	} beat_lanes_u;

endpackage

`default_nettype wire

/* verilog/rd_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rd_settings.svh"

interface rd_bus_if ();
	import rd_pkg::*;

	// address channel
	logic                  ar_valid;
	logic                  ar_ready;
	logic [`RD_ADDR_W-1:0] ar_addr;
	logic [`RD_LEN_W-1:0]  ar_len;
	rd_size_e              ar_size;

	// data channel, no id since the slot implies it
	logic                  r_valid;
	logic                  r_ready;
	logic [`RD_DATA_W-1:0] r_data;
	rd_resp_e              r_resp;
	logic                  r_last;

	modport chan (
		output ar_valid, ar_addr, ar_len, ar_size,
		input  ar_ready,
		input  r_valid, r_data, r_resp, r_last,
		output r_ready
	);

	modport arb (
		input  ar_valid, ar_addr, ar_len, ar_size,
		output ar_ready,
		output r_valid, r_data, r_resp, r_last,
		input  r_ready
	);

endinterface

`default_nettype wire

/* verilog/rd_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rd_settings.svh"

module rd_channel (
	input  wire                   clk,
	input  wire                   reset_n,
	// requestor side
	input  wire                   req_valid_i,
	input  wire [`RD_ADDR_W-1:0]  req_addr_i,
	input  wire [`RD_LEN_W-1:0]   req_len_i,
	input  wire rd_pkg::rd_size_e req_size_i,
	output logic                  req_ready_o,
	output logic                  rsp_valid_o,
	output logic [`RD_DATA_W-1:0] rsp_data_o,
	output rd_pkg::rd_resp_e      rsp_resp_o,
	output logic                  rsp_last_o,
	// toward the arbiter
	rd_bus_if.chan                bus
);
	import rd_pkg::*;

	localparam int OFF_W = $clog2(`RD_DATA_W/8);

	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_ADDR = 2'b01,
		ST_DATA = 2'b10
	} state_e;

	state_e state_q;
	state_e state_d;

	// latched request
	logic [`RD_ADDR_W-1:0] addr_q;
	logic [`RD_LEN_W-1:0]  len_q;
	rd_size_e              size_q;

	logic             req_hs;
	logic             ar_hs;
	logic             r_hs;
	logic [OFF_W-1:0] offset;

	beat_lanes_u           beat;
	logic [`RD_DATA_W-1:0] lane;

	assign req_hs = req_valid_i && req_ready_o;
	assign ar_hs  = bus.ar_valid && bus.ar_ready;
	assign r_hs   = bus.r_valid && bus.r_ready;

	assign req_ready_o = (state_q == ST_IDLE);
	assign bus.ar_valid = (state_q == ST_ADDR);
	assign bus.r_ready  = (state_q == ST_DATA);

	// burst always starts on a beat boundary
	assign bus.ar_addr = {addr_q[`RD_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
	assign bus.ar_len  = len_q;
	assign bus.ar_size = size_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (req_hs) state_d = ST_ADDR;
			ST_ADDR: if (ar_hs) state_d = ST_DATA;
			ST_DATA: if (r_hs && bus.r_last) state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (req_hs) begin
			addr_q <= req_addr_i;
			len_q  <= req_len_i;
			size_q <= req_size_i;
		end
	end

	// lane select by offset and size, result right aligned
	assign beat   = bus.r_data;
	assign offset = addr_q[OFF_W-1:0];

	always_comb begin
		lane = '0;
		case (size_q)
			SZ_B: lane[7:0]  = beat.bytes[offset];
			SZ_H: lane[15:0] = beat.halves[offset[OFF_W-1:1]];
			SZ_W: lane[31:0] = beat.words[offset[OFF_W-1:2]];
			default: lane = beat.dword;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= r_hs; // one pulse per beat
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			rsp_data_o <= lane;
			rsp_resp_o <= bus.r_resp;
			rsp_last_o <= bus.r_last;
		end
	end

	// address request must hold until the arbiter takes it
	ar_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
		bus.ar_valid && !bus.ar_ready |=> bus.ar_valid && $stable(bus.ar_addr)
			&& $stable(bus.ar_len) && $stable(bus.ar_size));

endmodule

`default_nettype wire

/* verilog/rd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rd_settings.svh"

module rd_arbiter #(
	parameter int N_PORTS = 2
) (
	input  wire                     clk,
	input  wire                     reset_n,
	rd_bus_if.arb                   slot [N_PORTS],
	// external AXI4 read port
	output logic                    m_ar_valid_o,
	output logic [`RD_ID_W-1:0]     m_ar_id_o,
	output logic [`RD_ADDR_W-1:0]   m_ar_addr_o,
	output logic [`RD_LEN_W-1:0]    m_ar_len_o,
	output logic [`RD_AXSIZE_W-1:0] m_ar_size_o,
	output logic [`RD_BURST_W-1:0]  m_ar_burst_o,
	input  wire                     m_ar_ready_i,
	input  wire                     m_r_valid_i,
	input  wire [`RD_ID_W-1:0]      m_r_id_i,
	input  wire [`RD_DATA_W-1:0]    m_r_data_i,
	input  wire rd_pkg::rd_resp_e   m_r_resp_i,
	input  wire                     m_r_last_i,
	output logic                    m_r_ready_o
);
	import rd_pkg::*;

	localparam int IDX_W = $clog2(N_PORTS);

	// slot signals flattened so they can be indexed at run time
	logic [N_PORTS-1:0]    ar_valid_v;
	logic [N_PORTS-1:0]    r_ready_v;
	logic [`RD_ADDR_W-1:0] ar_addr_v [N_PORTS];
	logic [`RD_LEN_W-1:0]  ar_len_v [N_PORTS];
	rd_size_e              ar_size_v [N_PORTS];

	logic [IDX_W-1:0] rr_q; // highest priority slot
	logic [IDX_W-1:0] pick;
	logic [IDX_W-1:0] grant;
	logic [IDX_W-1:0] grant_q;
	logic             lock_q;
	logic             ar_hs;
	logic [IDX_W-1:0] r_idx;
	logic             r_id_ok;

	for (genvar g = 0; g < N_PORTS; g++) begin : g_slot
		assign ar_valid_v[g] = slot[g].ar_valid;
		assign ar_addr_v[g]  = slot[g].ar_addr;
		assign ar_len_v[g]   = slot[g].ar_len;
		assign ar_size_v[g]  = slot[g].ar_size;
		assign r_ready_v[g]  = slot[g].r_ready;

		assign slot[g].ar_ready = m_ar_ready_i && (grant == g);
		assign slot[g].r_valid  = m_r_valid_i && (m_r_id_i == g);
		assign slot[g].r_data   = m_r_data_i; // broadcast, valid picks the slot
		assign slot[g].r_resp   = m_r_resp_i;
		assign slot[g].r_last   = m_r_last_i;
	end

	// first requesting slot at or after the pointer
	always_comb begin
		int   cand;
		logic found;
		pick  = rr_q;
		found = 1'b0;
		for (int k = 0; k < N_PORTS; k++) begin
			cand = (int'(rr_q) + k) % N_PORTS;
			if (!found && ar_valid_v[cand]) begin
				pick  = IDX_W'(cand);
				found = 1'b1;
			end
		end
	end

	assign grant = lock_q ? grant_q : pick; // hold while the slave stalls

	assign m_ar_valid_o = ar_valid_v[grant];
	assign m_ar_id_o    = `RD_ID_W'(grant);
	assign m_ar_addr_o  = ar_addr_v[grant];
	assign m_ar_len_o   = ar_len_v[grant];
	assign m_ar_size_o  = `RD_AXSIZE_W'(ar_size_v[grant]);
	assign m_ar_burst_o = `RD_BURST_INCR;

	assign ar_hs = m_ar_valid_o && m_ar_ready_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rr_q   <= '0;
			lock_q <= 1'b0;
		end else begin
			lock_q <= m_ar_valid_o && !m_ar_ready_i;
			if (ar_hs) begin
				rr_q <= (grant == IDX_W'(N_PORTS - 1)) ? '0 : grant + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		grant_q <= grant;
	end

	// r_ready comes back from whichever slot the id names
	assign r_idx       = m_r_id_i[IDX_W-1:0];
	assign r_id_ok     = (m_r_id_i < N_PORTS);
	assign m_r_ready_o = r_id_ok ? r_ready_v[r_idx] : 1'b0;

	r_id_range_a: assert property (@(posedge clk) disable iff (!reset_n)
		m_r_valid_i |-> m_r_id_i < N_PORTS);

endmodule

`default_nettype wire

/* verilog/rd_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rd_settings.svh"

module rd_subsys_top (
	input  wire                                     clk,
	input  wire                                     reset_n,
	// requestor ports, one slice per engine
	input  wire [`RD_PORTS-1:0]                     req_valid_i,
	input  wire [`RD_PORTS-1:0][`RD_ADDR_W-1:0]     req_addr_i,
	input  wire [`RD_PORTS-1:0][`RD_LEN_W-1:0]      req_len_i,
	input  wire rd_pkg::rd_size_e [`RD_PORTS-1:0]   req_size_i,
	output logic [`RD_PORTS-1:0]                    req_ready_o,
	output logic [`RD_PORTS-1:0]                    rsp_valid_o,
	output logic [`RD_PORTS-1:0][`RD_DATA_W-1:0]    rsp_data_o,
	output rd_pkg::rd_resp_e [`RD_PORTS-1:0]        rsp_resp_o,
	output logic [`RD_PORTS-1:0]                    rsp_last_o,
	// external AXI4 read port
	output logic                                    m_ar_valid_o,
	output logic [`RD_ID_W-1:0]                     m_ar_id_o,
	output logic [`RD_ADDR_W-1:0]                   m_ar_addr_o,
	output logic [`RD_LEN_W-1:0]                    m_ar_len_o,
	output logic [`RD_AXSIZE_W-1:0]                 m_ar_size_o,
	output logic [`RD_BURST_W-1:0]                  m_ar_burst_o,
	input  wire                                     m_ar_ready_i,
	input  wire                                     m_r_valid_i,
	input  wire [`RD_ID_W-1:0]                      m_r_id_i,
	input  wire [`RD_DATA_W-1:0]                    m_r_data_i,
	input  wire rd_pkg::rd_resp_e                   m_r_resp_i,
	input  wire                                     m_r_last_i,
	output logic                                    m_r_ready_o
);

	rd_bus_if bus [`RD_PORTS] (); // one link per engine

	for (genvar g = 0; g < `RD_PORTS; g++) begin : g_chan
		rd_channel i_chan (
			.clk         (clk),
			.reset_n     (reset_n),
			.req_valid_i (req_valid_i[g]),
			.req_addr_i  (req_addr_i[g]),
			.req_len_i   (req_len_i[g]),
			.req_size_i  (req_size_i[g]),
			.req_ready_o (req_ready_o[g]),
			.rsp_valid_o (rsp_valid_o[g]),
			.rsp_data_o  (rsp_data_o[g]),
			.rsp_resp_o  (rsp_resp_o[g]),
			.rsp_last_o  (rsp_last_o[g]),
			.bus         (bus[g])
		);
	end

	rd_arbiter #(
		.N_PORTS (`RD_PORTS)
	) i_arb (
		.clk          (clk),
		.reset_n      (reset_n),
		.slot         (bus),
		.m_ar_valid_o (m_ar_valid_o),
		.m_ar_id_o    (m_ar_id_o),
		.m_ar_addr_o  (m_ar_addr_o),
		.m_ar_len_o   (m_ar_len_o),
		.m_ar_size_o  (m_ar_size_o),
		.m_ar_burst_o (m_ar_burst_o),
		.m_ar_ready_i (m_ar_ready_i),
		.m_r_valid_i  (m_r_valid_i),
		.m_r_id_i     (m_r_id_i),
		.m_r_data_i   (m_r_data_i),
		.m_r_resp_i   (m_r_resp_i),
		.m_r_last_i   (m_r_last_i),
		.m_r_ready_o  (m_r_ready_o)
	);

endmodule

`default_nettype wire

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rd_settings.svh"

module axi_mem_model #(
	parameter int          N_IDS = 2,
	parameter logic [31:0] SEED  = 32'h1
) (
	input  wire                   clk,
	input  wire                   reset_n,
	input  wire                   ar_valid_i,
	input  wire [`RD_ID_W-1:0]    ar_id_i,
	input  wire [`RD_ADDR_W-1:0]  ar_addr_i,
	input  wire [`RD_LEN_W-1:0]   ar_len_i,
	output logic                  ar_ready_o,
	output logic                  r_valid_o,
	output logic [`RD_ID_W-1:0]   r_id_o,
	output logic [`RD_DATA_W-1:0] r_data_o,
	output rd_pkg::rd_resp_e      r_resp_o,
	output logic                  r_last_o,
	input  wire                   r_ready_i
);
	import rd_pkg::*;

	integer                seed;
	logic [44:0]           bq [$]; // {id, beats, addr} in arrival order
	logic                  act [N_IDS]; // one open burst per id
	logic [`RD_ADDR_W-1:0] b_addr [N_IDS];
	int                    b_left [N_IDS];

	function automatic logic [7:0] mem_byte(logic [31:0] k);
		return 8'(k * 32'h3b + (k >> 8));
	endfunction

	task automatic present_beat(input int idx);
		r_valid_o = 1'b1;
		r_id_o    = `RD_ID_W'(idx);
		for (int j = 0; j < 8; j++) r_data_o[8*j +: 8] = mem_byte(b_addr[idx] + 32'(j));
		r_resp_o = b_addr[idx][31] ? SLVERR : OKAY; // upper half of the map faults
		r_last_o = (b_left[idx] == 1);
	endtask

	initial begin
		seed       = SEED;
		ar_ready_o = 1'b0;
		r_valid_o  = 1'b0;
		r_id_o     = '0;
		r_data_o   = '0;
		r_resp_o   = OKAY;
		r_last_o   = 1'b0;
	end

	always @(posedge clk) begin
		logic        ar_hs;
		logic        r_hs;
		logic [44:0] ar_word;
		logic [31:0] rnd;
		int          id;
		int          start;
		logic        found;
		ar_hs   = ar_valid_i && ar_ready_o;
		r_hs    = r_valid_o && r_ready_i;
		ar_word = {ar_id_i, {1'b0, ar_len_i} + 9'd1, ar_addr_i}; // taken before the inputs move
		#1;
		if (!reset_n) begin
			bq.delete();
			for (int i = 0; i < N_IDS; i++) act[i] = 1'b0;
			ar_ready_o = 1'b0;
			r_valid_o  = 1'b0;
		end else begin
			if (ar_hs) bq.push_back(ar_word);
			if (r_hs) begin
				id         = int'(r_id_o);
				b_addr[id] = b_addr[id] + 32'd8;
				b_left[id] = b_left[id] - 1;
				if (b_left[id] == 0) act[id] = 1'b0;
				r_valid_o = 1'b0;
			end
			if (bq.size() > 0 && !act[int'(bq[0][44:41])]) begin
				ar_word    = bq.pop_front();
				id         = int'(ar_word[44:41]);
				act[id]    = 1'b1;
				b_left[id] = int'(ar_word[40:32]);
				b_addr[id] = ar_word[31:0];
			end
			rnd        = $random(seed);
			ar_ready_o = rnd[1:0] != 2'b00; // stalls about one cycle in four
			found      = 1'b0;
			start      = int'(rnd[7:4]) % N_IDS; // random id first, so bursts interleave
			for (int k = 0; k < N_IDS; k++) begin
				if (!r_valid_o && rnd[2] && !found && act[(start + k) % N_IDS]) begin
					found = 1'b1;
					present_beat((start + k) % N_IDS);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_rd_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rd_settings.svh"

module tb_rd_subsys;
	import rd_pkg::*;

	localparam int P       = `RD_PORTS;
	localparam int N_REQ   = 60;    // requests per port
	localparam int TIMEOUT = 50000; // cycles

	localparam logic [1:0] BURST_INCR = 2'b01; // AXI burst type encoding

	logic                           clk;
	logic                           reset_n;
	logic [P-1:0]                   req_valid_i;
	logic [P-1:0][`RD_ADDR_W-1:0]   req_addr_i;
	logic [P-1:0][`RD_LEN_W-1:0]    req_len_i;
	rd_size_e [P-1:0]               req_size_i;
	logic [P-1:0]                   req_ready_o;
	logic [P-1:0]                   rsp_valid_o;
	logic [P-1:0][`RD_DATA_W-1:0]   rsp_data_o;
	rd_resp_e [P-1:0]               rsp_resp_o;
	logic [P-1:0]                   rsp_last_o;
	logic                           ar_valid;
	logic [`RD_ID_W-1:0]            ar_id;
	logic [`RD_ADDR_W-1:0]          ar_addr;
	logic [`RD_LEN_W-1:0]           ar_len;
	logic [`RD_AXSIZE_W-1:0]        ar_size;
	logic [`RD_BURST_W-1:0]         ar_burst;
	logic                           ar_ready;
	logic                           r_valid;
	logic [`RD_ID_W-1:0]            r_id;
	logic [`RD_DATA_W-1:0]          r_data;
	rd_resp_e                       r_resp;
	logic                           r_last;
	logic                           r_ready;

	integer                seed;
	int                    err_count;
	int                    beat_count;
	int                    sent [P];
	logic [66:0]           exp_q [P][$]; // {last, resp, data}
	logic [`RD_ADDR_W-1:0] ar_exp [P];
	logic [`RD_LEN_W-1:0]  len_exp [P];
	logic [1:0]            size_exp [P]; // log2 of the byte count

	rd_subsys_top i_dut (
		.clk (clk), .reset_n (reset_n),
		.req_valid_i (req_valid_i), .req_addr_i (req_addr_i), .req_len_i (req_len_i),
		.req_size_i (req_size_i), .req_ready_o (req_ready_o), .rsp_valid_o (rsp_valid_o),
		.rsp_data_o (rsp_data_o), .rsp_resp_o (rsp_resp_o), .rsp_last_o (rsp_last_o),
		.m_ar_valid_o (ar_valid), .m_ar_id_o (ar_id), .m_ar_addr_o (ar_addr),
		.m_ar_len_o (ar_len), .m_ar_size_o (ar_size), .m_ar_burst_o (ar_burst),
		.m_ar_ready_i (ar_ready), .m_r_valid_i (r_valid), .m_r_id_i (r_id),
		.m_r_data_i (r_data), .m_r_resp_i (r_resp), .m_r_last_i (r_last),
		.m_r_ready_o (r_ready)
	);

	axi_mem_model #(.N_IDS (P), .SEED (32'h4d87)) i_mem (
		.clk (clk), .reset_n (reset_n),
		.ar_valid_i (ar_valid), .ar_id_i (ar_id), .ar_addr_i (ar_addr), .ar_len_i (ar_len),
		.ar_ready_o (ar_ready), .r_valid_o (r_valid), .r_id_o (r_id), .r_data_o (r_data),
		.r_resp_o (r_resp), .r_last_o (r_last), .r_ready_i (r_ready)
	);

	always #2 clk = ~clk;

	function automatic logic [7:0] mem_byte(logic [31:0] k);
		return 8'(k * 32'h3b + (k >> 8));
	endfunction

	// bytes of beat i picked by offset and size, right aligned
	function automatic logic [63:0] beat_lane(logic [31:0] addr, logic [1:0] size, int i);
		logic [31:0] first;
		logic [63:0] v;
		first = {addr[31:3], 3'b000} + 32'(i) * 32'd8 + {29'd0, addr[2:0]};
		v = '0;
		for (int j = 0; j < (1 << size); j++) v[8*j +: 8] = mem_byte(first + 32'(j));
		return v;
	endfunction

	function automatic logic all_done();
		logic done;
		done = 1'b1;
		for (int p = 0; p < P; p++) begin
			if (sent[p] < N_REQ || req_valid_i[p] || exp_q[p].size() != 0 || !req_ready_o[p])
				done = 1'b0;
		end
		return done;
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, got %h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic new_request(input int p);
		logic [31:0] addr;
		logic [31:0] rnd;
		addr = $random(seed);
		rnd  = $random(seed);
		req_addr_i[p]  = addr & ~((32'd1 << rnd[1:0]) - 32'd1); // aligned to the size
		req_size_i[p]  = rd_size_e'(rnd[1:0]);
		req_len_i[p]   = {5'd0, rnd[4:2]};
		req_valid_i[p] = 1'b1;
	endtask

	task automatic push_beats(input int p);
		logic [31:0] beat_addr;
		rd_resp_e    resp;
		for (int i = 0; i <= int'(req_len_i[p]); i++) begin
			beat_addr = {req_addr_i[p][31:3], 3'b000} + 32'(i) * 32'd8;
			resp = beat_addr[31] ? SLVERR : OKAY;
			exp_q[p].push_back({i == int'(req_len_i[p]), resp,
				beat_lane(req_addr_i[p], req_size_i[p], i)});
		end
		ar_exp[p]   = {req_addr_i[p][31:3], 3'b000};
		len_exp[p]  = req_len_i[p];
		size_exp[p] = req_size_i[p];
		sent[p]++;
	endtask

	task automatic check_beat(input int p);
		logic [66:0] e;
		if (exp_q[p].size() == 0) begin
			$display("port %0d returned a beat with no request outstanding", p);
			err_count++;
		end else begin
			e = exp_q[p].pop_front();
			check_val($sformatf("rsp_data_o[%0d]", p), e[63:0], rsp_data_o[p]);
			check_val($sformatf("rsp_resp_o[%0d]", p), 64'(e[65:64]), 64'(rsp_resp_o[p]));
			check_val($sformatf("rsp_last_o[%0d]", p), 64'(e[66]), 64'(rsp_last_o[p]));
			beat_count++;
		end
	endtask

	task automatic check_ar();
		check_val("m_ar_addr_o[2:0]", 64'd0, 64'(ar_addr[2:0]));
		check_val("m_ar_burst_o", 64'(BURST_INCR), 64'(ar_burst));
		if (int'(ar_id) >= P) begin
			$display("AR id %0d does not name any requestor", ar_id);
			err_count++;
		end else begin
			check_val("m_ar_addr_o", 64'(ar_exp[int'(ar_id)]), 64'(ar_addr));
			check_val("m_ar_len_o", 64'(len_exp[int'(ar_id)]), 64'(ar_len));
			check_val("m_ar_size_o", 64'(size_exp[int'(ar_id)]), 64'(ar_size));
		end
	endtask

	// sample at the edge, drive 1 ns later
	always @(posedge clk) begin
		logic [P-1:0] taken;
		logic [31:0]  rnd;
		taken = req_valid_i & req_ready_o;
		if (reset_n) begin
			for (int p = 0; p < P; p++) begin
				if (rsp_valid_o[p]) check_beat(p);
				if (taken[p]) push_beats(p);
			end
			if (ar_valid && ar_ready) check_ar();
			#1;
			for (int p = 0; p < P; p++) begin
				rnd = $random(seed);
				if (taken[p]) req_valid_i[p] = 1'b0;
				if (!req_valid_i[p] && sent[p] < N_REQ && rnd[0]) new_request(p);
			end
		end
	end

	initial begin
		int cycles;
		seed        = 32'h4d87;
		err_count   = 0;
		beat_count  = 0;
		clk         = 1'b0;
		reset_n     = 1'b0;
		req_valid_i = '0;
		req_addr_i  = '0;
		req_len_i   = '0;
		for (int p = 0; p < P; p++) begin
			req_size_i[p] = SZ_B;
			sent[p]       = 0;
		end
		repeat (5) @(posedge clk);
		#1;
		check_val("req_ready_o", 64'({P{1'b1}}), 64'(req_ready_o));
		check_val("m_ar_valid_o", 64'd0, 64'(ar_valid));
		check_val("rsp_valid_o", 64'd0, 64'(rsp_valid_o));
		reset_n = 1'b1;
		cycles  = 0;
		while (!all_done() && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!all_done()) begin
			$display("timeout, requests still open after %0d cycles", TIMEOUT);
			err_count++;
		end
		$display("errors: %0d, beats checked: %0d", err_count, beat_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/rd_pkg.sv
verilog/rd_bus_if.sv
verilog/rd_channel.sv
verilog/rd_arbiter.sv
verilog/rd_subsys_top.sv
testbench/axi_mem_model.sv
testbench/tb_rd_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rd_subsys
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
